// File: axil_noc_bridge.f
+incdir+include
source/bridge_pkg.sv
source/req_fifo.sv
source/store_queue.sv
source/load_queue.sv
source/flit_serializer.sv
source/axil_noc_bridge.sv
tb/tb_axil_noc_bridge.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the bridge testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_axil_noc_bridge \
    -f axil_noc_bridge.f \
    -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qx "Regression passed" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// File: source/axil_noc_bridge.sv
//##########################################################
// AXI-Lite to NoC request bridge
// store and load queues feeding one flit serializer
//##########################################################
`timescale 1ns/10ps

module axil_noc_bridge (
    input  logic                    clk,
    input  logic                    rst_n,
    input  bridge_pkg::node_id_t    src_id,
    input  bridge_pkg::node_id_t    dest_id,
    input  bridge_pkg::axil_aw_t    aw,
    input  logic                    aw_valid,
    output logic                    aw_ready,
    input  bridge_pkg::axil_w_t     w,
    input  logic                    w_valid,
    output logic                    w_ready,
    input  bridge_pkg::axil_aw_t    ar,
    input  logic                    ar_valid,
    output logic                    ar_ready,
    output logic                    noc_valid,
    output bridge_pkg::flit_t       noc_data,
    input  logic                    noc_ready
);

    logic                   store_valid;
    bridge_pkg::store_req_t store_req;
    logic                   store_accepted;
    logic                   store_pop;
    logic                   load_valid;
    bridge_pkg::load_req_t  load_req;
    logic                   load_accepted;
    logic                   load_pop;

    store_queue u_store_queue (
        .clk            (clk),
        .rst_n          (rst_n),
        .aw             (aw),
        .aw_valid       (aw_valid),
        .aw_ready       (aw_ready),
        .w              (w),
        .w_valid        (w_valid),
        .w_ready        (w_ready),
        .store_pop      (store_pop),
        .store_valid    (store_valid),
        .store_req      (store_req),
        .store_accepted (store_accepted)
    );

    load_queue u_load_queue (
        .clk           (clk),
        .rst_n         (rst_n),
        .ar            (ar),
        .ar_valid      (ar_valid),
        .ar_ready      (ar_ready),
        .load_pop      (load_pop),
        .load_valid    (load_valid),
        .load_req      (load_req),
        .load_accepted (load_accepted)
    );

    flit_serializer u_flit_serializer (
        .clk            (clk),
        .rst_n          (rst_n),
        .src_id         (src_id),
        .dest_id        (dest_id),
        .store_valid    (store_valid),
        .store_req      (store_req),
        .store_accepted (store_accepted),
        .store_pop      (store_pop),
        .load_valid     (load_valid),
        .load_req       (load_req),
        .load_accepted  (load_accepted),
        .load_pop       (load_pop),
        .noc_valid      (noc_valid),
        .noc_data       (noc_data),
        .noc_ready      (noc_ready)
    );

endmodule

// File: source/bridge_pkg.sv
//##########################################################
// bridge package
// widths, flit field layouts, message codes and queue
// depths shared by the AXI-Lite to NoC request bridge
//##########################################################

package bridge_pkg;

    // plain vectors with a meaning
    typedef logic [63:0] axi_addr_t;
    typedef logic [63:0] axi_data_t;
    typedef logic [7:0]  axi_strb_t;   // one bit per byte
    typedef logic [63:0] flit_t;

    // network endpoint, 34 bits
    typedef struct packed {
        logic [13:0] chip_id;
        logic [7:0]  x_pos;
        logic [7:0]  y_pos;
        logic [3:0]  fbits;
    } node_id_t;

    // AXI-Lite beats
    typedef struct packed {
        axi_addr_t addr;
    } axil_aw_t;

    typedef struct packed {
        axi_data_t data;
        axi_strb_t strb;
    } axil_w_t;

    // requests handed from the queues to the serializer
    typedef struct packed {
        axi_addr_t addr;
        axi_data_t data;
        axi_strb_t strb;
    } store_req_t;

    typedef struct packed {
        axi_addr_t addr;
    } load_req_t;

    typedef enum logic [7:0] {
        MSG_TYPE_STORE_REQ = 8'd15,
        MSG_TYPE_LOAD_REQ  = 8'd31
    } msg_type_t;

    // header flits, high bits first
    typedef struct packed {
        node_id_t    dest;
        logic [7:0]  msg_len;    // flits after the first one
        msg_type_t   msg_type;
        logic [7:0]  mshr_id;
        logic [5:0]  options;
    } hdr1_t;

    typedef struct packed {
        logic [7:0]  byte_mask;
        logic [4:0]  spare;
        logic [2:0]  data_size;
        logic [47:0] phys_addr;
    } hdr2_t;

    typedef struct packed {
        node_id_t    src;
        logic [29:0] rsvd;
    } hdr3_t;

    // one arrival slot in the order queue
    typedef struct packed {
        logic load;
        logic store;
    } order_entry_t;

    localparam logic [7:0] MSG_LEN_STORE = 8'd3;   // hdr2, hdr3, data
    localparam logic [7:0] MSG_LEN_LOAD  = 8'd2;
    localparam logic [2:0] DATA_SIZE_8B  = 3'b100;

    localparam int QUEUE_DEPTH = 4;
    localparam int ORDER_DEPTH = 8;   // holds every outstanding load and store

    typedef enum logic [2:0] {
        IDLE,
        HDR1,
        HDR2,
        HDR3,
        DATA
    } ser_state_t;

endpackage

// File: source/flit_serializer.sv
//##########################################################
// flit serializer
// keeps the arrival order of loads and stores and sends
// each one as header flits, plus a data flit for stores
//##########################################################
`timescale 1ns/10ps

module flit_serializer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  bridge_pkg::node_id_t    src_id,
    input  bridge_pkg::node_id_t    dest_id,
    input  logic                    store_valid,
    input  bridge_pkg::store_req_t  store_req,
    input  logic                    store_accepted,
    output logic                    store_pop,
    input  logic                    load_valid,
    input  bridge_pkg::load_req_t   load_req,
    input  logic                    load_accepted,
    output logic                    load_pop,
    output logic                    noc_valid,
    output bridge_pkg::flit_t       noc_data,
    input  logic                    noc_ready
);

    bridge_pkg::ser_state_t   state;
    bridge_pkg::ser_state_t   state_next;
    bridge_pkg::order_entry_t order_in;
    bridge_pkg::order_entry_t order_head;
    logic                     order_push;
    logic                     order_pop;
    logic                     order_empty;
    logic                     load_done;    // load half of a paired entry is out
    logic                     serve_load;
    logic                     head_ready;
    logic                     cur_store;    // packet in flight is a store
    bridge_pkg::axi_addr_t    cur_addr;
    bridge_pkg::axi_strb_t    strb_rev;
    bridge_pkg::axi_data_t    data_rev;
    bridge_pkg::hdr1_t        hdr1;
    bridge_pkg::hdr2_t        hdr2;
    bridge_pkg::hdr3_t        hdr3;

    // one slot per cycle in which anything was accepted
    assign order_push     = store_accepted || load_accepted;
    assign order_in.load  = load_accepted;
    assign order_in.store = store_accepted;

    req_fifo #(
        .WIDTH ($bits(bridge_pkg::order_entry_t)),
        .DEPTH (bridge_pkg::ORDER_DEPTH)
    ) u_order_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (order_push),
        .push_data (order_in),
        .pop       (order_pop),
        .pop_data  (order_head),
        .full      (),
        .empty     (order_empty)
    );

    // paired entry goes load first
    assign serve_load = order_head.load && !load_done;
    assign head_ready = !order_empty && (serve_load ? load_valid : store_valid);

    always_comb begin
        state_next = state;
        case (state)
            bridge_pkg::IDLE: if (head_ready) state_next = bridge_pkg::HDR1;
            bridge_pkg::HDR1: if (noc_ready)  state_next = bridge_pkg::HDR2;
            bridge_pkg::HDR2: if (noc_ready)  state_next = bridge_pkg::HDR3;
            bridge_pkg::HDR3: begin
                if (noc_ready) begin
                    if (cur_store) state_next = bridge_pkg::DATA;
                    else           state_next = bridge_pkg::IDLE;
                end
            end
            bridge_pkg::DATA: if (noc_ready)  state_next = bridge_pkg::IDLE;
            default:          state_next = bridge_pkg::IDLE;
        endcase
    end

    // pops land on the handshake of the last flit
    assign load_pop  = (state == bridge_pkg::HDR3) && noc_ready && !cur_store;
    assign store_pop = (state == bridge_pkg::DATA) && noc_ready;
    assign order_pop = store_pop || (load_pop && !order_head.store);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= bridge_pkg::IDLE;
            cur_store <= 1'b0;
            load_done <= 1'b0;
        end else begin
            state <= state_next;
            if (state == bridge_pkg::IDLE && head_ready) cur_store <= !serve_load;
            if (store_pop)
                load_done <= 1'b0;
            else if (load_pop && order_head.store)
                load_done <= 1'b1;   // store half still waiting
        end
    end

    assign cur_addr = cur_store ? store_req.addr : load_req.addr;
    assign strb_rev = {<<{store_req.strb}};
    assign data_rev = {<<8{store_req.data}};   // byte order of the network

    always_comb begin
        hdr1         = '0;
        hdr1.dest    = dest_id;
        hdr1.msg_len = cur_store ? bridge_pkg::MSG_LEN_STORE : bridge_pkg::MSG_LEN_LOAD;
        if (cur_store) hdr1.msg_type = bridge_pkg::MSG_TYPE_STORE_REQ;
        else           hdr1.msg_type = bridge_pkg::MSG_TYPE_LOAD_REQ;

        hdr2           = '0;
        hdr2.byte_mask = cur_store ? strb_rev : '0;
        hdr2.data_size = bridge_pkg::DATA_SIZE_8B;
        hdr2.phys_addr = cur_addr[47:0];

        hdr3     = '0;
        hdr3.src = src_id;
    end

    always_comb begin
        case (state)
            bridge_pkg::HDR1: noc_data = hdr1;
            bridge_pkg::HDR2: noc_data = hdr2;
            bridge_pkg::HDR3: noc_data = hdr3;
            bridge_pkg::DATA: noc_data = data_rev;
            default:          noc_data = '0;
        endcase
    end

    assign noc_valid = (state != bridge_pkg::IDLE);

endmodule

// File: source/load_queue.sv
//##########################################################
// load queue
// buffers AXI read-address beats and presents them as
// load requests in arrival order
//##########################################################
`timescale 1ns/10ps

module load_queue (
    input  logic                    clk,
    input  logic                    rst_n,
    input  bridge_pkg::axil_aw_t    ar,
    input  logic                    ar_valid,
    output logic                    ar_ready,
    input  logic                    load_pop,
    output logic                    load_valid,
    output bridge_pkg::load_req_t   load_req,
    output logic                    load_accepted
);

    bridge_pkg::axil_aw_t ar_head;
    logic                 ar_full;
    logic                 ar_empty;
    logic                 ar_take;

    assign ar_ready = !ar_full;
    assign ar_take  = ar_valid && ar_ready;

    // one pulse per taken read address
    assign load_accepted = ar_take;

    req_fifo #(
        .WIDTH ($bits(bridge_pkg::axil_aw_t)),
        .DEPTH (bridge_pkg::QUEUE_DEPTH)
    ) u_ar_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (ar_take),
        .push_data (ar),
        .pop       (load_pop),
        .pop_data  (ar_head),
        .full      (ar_full),
        .empty     (ar_empty)
    );

    assign load_valid    = !ar_empty;
    assign load_req.addr = ar_head.addr;

endmodule

// File: source/req_fifo.sv
//##########################################################
// request FIFO
// register-array buffer with full and empty flags,
// push and pop allowed in the same cycle
//##########################################################
`timescale 1ns/10ps

module req_fifo #(
    parameter int WIDTH = 64,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             pop,
    output logic [WIDTH-1:0] pop_data,
    output logic             full,
    output logic             empty
);

    typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(DEPTH+1)-1:0] count_t;

    logic [WIDTH-1:0] mem [DEPTH];
    ptr_t             wr_ptr;
    ptr_t             rd_ptr;
    count_t           count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full     = (count == count_t'(DEPTH));
    assign empty    = (count == '0);
    assign pop_data = mem[rd_ptr];   // head is always on the output

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
        end
    end

endmodule

// File: source/store_queue.sv
//##########################################################
// store queue
// buffers AXI write-address and write-data beats on their
// own and pairs them into complete store requests
//##########################################################
`timescale 1ns/10ps

module store_queue (
    input  logic                    clk,
    input  logic                    rst_n,
    input  bridge_pkg::axil_aw_t    aw,
    input  logic                    aw_valid,
    output logic                    aw_ready,
    input  bridge_pkg::axil_w_t     w,
    input  logic                    w_valid,
    output logic                    w_ready,
    input  logic                    store_pop,
    output logic                    store_valid,
    output bridge_pkg::store_req_t  store_req,
    output logic                    store_accepted
);

    bridge_pkg::axil_aw_t aw_head;
    bridge_pkg::axil_w_t  w_head;
    logic                 aw_full;
    logic                 aw_empty;
    logic                 w_full;
    logic                 w_empty;
    logic                 aw_take;
    logic                 w_take;

    assign aw_ready = !aw_full;
    assign w_ready  = !w_full;
    assign aw_take  = aw_valid && aw_ready;
    assign w_take   = w_valid && w_ready;

    // the address beat sets the arrival order of the store
    assign store_accepted = aw_take;

    req_fifo #(
        .WIDTH ($bits(bridge_pkg::axil_aw_t)),
        .DEPTH (bridge_pkg::QUEUE_DEPTH)
    ) u_aw_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (aw_take),
        .push_data (aw),
        .pop       (store_pop),
        .pop_data  (aw_head),
        .full      (aw_full),
        .empty     (aw_empty)
    );

    req_fifo #(
        .WIDTH ($bits(bridge_pkg::axil_w_t)),
        .DEPTH (bridge_pkg::QUEUE_DEPTH)
    ) u_w_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (w_take),
        .push_data (w),
        .pop       (store_pop),
        .pop_data  (w_head),
        .full      (w_full),
        .empty     (w_empty)
    );

    // a store needs both halves, whichever came first
    assign store_valid = !aw_empty && !w_empty;

    assign store_req.addr = aw_head.addr;
    assign store_req.data = w_head.data;
    assign store_req.strb = w_head.strb;

endmodule

// File: include/bridge_tb_tasks.svh
//##########################################################
// bridge testbench tasks
// AXI channel driver, expected-flit model, flit compare
// and the directed scenarios
//##########################################################
`ifndef BRIDGE_TB_TASKS_SVH
`define BRIDGE_TB_TASKS_SVH

task automatic next_cycle();
    @(posedge clk);
    #1;   // inputs move just after the edge
endtask

function automatic void mismatch(input string sig, input logic [63:0] exp_val,
                                 input logic [63:0] got_val);
    $display("FAILED at %0t: %s expected %h got %h", $time, sig, exp_val, got_val);
    errors++;
endfunction

// raise valid on the chosen channels, drop each one once it is taken
task automatic handshake(input logic on_aw, input logic on_w, input logic on_ar);
    logic take_aw;
    logic take_w;
    logic take_ar;
    int   n;
    aw_valid = on_aw;
    w_valid  = on_w;
    ar_valid = on_ar;
    for (n = 0; n < TIMEOUT && (aw_valid || w_valid || ar_valid); n++) begin
        take_aw = aw_ready;   // ready does not depend on valid
        take_w  = w_ready;
        take_ar = ar_ready;
        next_cycle();
        if (take_aw) aw_valid = 1'b0;
        if (take_w)  w_valid  = 1'b0;
        if (take_ar) ar_valid = 1'b0;
    end
    if (aw_valid || w_valid || ar_valid) begin
        $display("an AXI beat was not accepted within %0d cycles", TIMEOUT);
        timeouts++;
        aw_valid = 1'b0;
        w_valid  = 1'b0;
        ar_valid = 1'b0;
    end
endtask

// expected flits of one packet, built field by field
task automatic expect_packet(input logic is_store, input bridge_pkg::axi_addr_t addr,
                             input bridge_pkg::axi_data_t data,
                             input bridge_pkg::axi_strb_t strb);
    bridge_pkg::hdr1_t h1;
    bridge_pkg::hdr2_t h2;
    bridge_pkg::hdr3_t h3;
    bridge_pkg::flit_t swapped;
    int                i;
    h1 = '0;
    h2 = '0;
    h3 = '0;
    h1.dest      = dest_id;
    h1.msg_len   = is_store ? 8'd3 : 8'd2;   // flits after hdr1
    h1.msg_type  = bridge_pkg::MSG_TYPE_LOAD_REQ;
    if (is_store) h1.msg_type = bridge_pkg::MSG_TYPE_STORE_REQ;
    h2.data_size = 3'b100;
    h2.phys_addr = addr[47:0];
    h3.src       = src_id;
    for (i = 0; i < 8; i++) begin
        h2.byte_mask[7-i]     = is_store & strb[i];
        swapped[8*(7-i) +: 8] = data[8*i +: 8];   // lane i moves to lane 7-i
    end
    exp_q.push_back(bridge_pkg::flit_t'(h1));
    exp_q.push_back(bridge_pkg::flit_t'(h2));
    exp_q.push_back(bridge_pkg::flit_t'(h3));
    if (is_store) exp_q.push_back(swapped);
endtask

// wait for the expected flits, leave a quiet gap, then compare in order
task automatic check_packets(input string name);
    bridge_pkg::flit_t exp_f;
    bridge_pkg::flit_t got_f;
    int                n;
    for (n = 0; n < TIMEOUT && got_q.size() < exp_q.size(); n++) next_cycle();
    if (got_q.size() < exp_q.size()) begin
        $display("%s: only %0d of %0d flits arrived in time", name, got_q.size(), exp_q.size());
        timeouts++;
    end
    repeat (12) next_cycle();   // any extra flit shows up here
    if (got_q.size() != exp_q.size())
        mismatch({name, " noc_valid handshakes"}, 64'(exp_q.size()), 64'(got_q.size()));
    while (exp_q.size() > 0 && got_q.size() > 0) begin
        exp_f = exp_q.pop_front();
        got_f = got_q.pop_front();
        if (got_f !== exp_f) mismatch({name, " noc_data"}, exp_f, got_f);
    end
    exp_q.delete();
    got_q.delete();
endtask

task automatic single_load();
    ar.addr = 64'h0000_1234_5678_9ab8;
    expect_packet(1'b0, ar.addr, '0, '0);
    handshake(1'b0, 1'b0, 1'b1);
    check_packets("single_load");
endtask

task automatic single_store();
    aw.addr = 64'h0000_00ab_cdef_0040;
    w.data  = 64'h1122_3344_5566_7788;
    w.strb  = 8'b0000_1101;
    expect_packet(1'b1, aw.addr, w.data, w.strb);
    handshake(1'b1, 1'b1, 1'b0);
    check_packets("single_store");
endtask

task automatic write_data_first();
    w.data = 64'hdead_beef_0bad_f00d;
    w.strb = 8'b1111_0000;
    handshake(1'b0, 1'b1, 1'b0);
    repeat (6) next_cycle();
    // store is incomplete without its address
    if (got_q.size() != 0) mismatch("noc_valid handshakes before AW", 64'd0, 64'(got_q.size()));
    aw.addr = 64'h0000_7fff_0000_1008;
    expect_packet(1'b1, aw.addr, w.data, w.strb);
    handshake(1'b1, 1'b0, 1'b0);
    check_packets("write_data_first");
endtask

task automatic mixed_ordering();
    ar.addr = 64'h0000_0000_0000_0100;
    expect_packet(1'b0, ar.addr, '0, '0);
    handshake(1'b0, 1'b0, 1'b1);
    aw.addr = 64'h0000_0000_0000_0208;
    w.data  = 64'h0123_4567_89ab_cdef;
    w.strb  = 8'hff;
    expect_packet(1'b1, aw.addr, w.data, w.strb);
    handshake(1'b1, 1'b1, 1'b0);
    aw.addr = 64'h0000_0000_0000_0310;
    ar.addr = 64'h0000_0000_0000_0418;
    w.data  = 64'hfedc_ba98_7654_3210;
    w.strb  = 8'h3c;
    expect_packet(1'b0, ar.addr, '0, '0);   // same-cycle pair, load goes first
    expect_packet(1'b1, aw.addr, w.data, w.strb);
    handshake(1'b1, 1'b0, 1'b1);
    handshake(1'b0, 1'b1, 1'b0);
    ar.addr = 64'h0000_0000_0000_0520;
    expect_packet(1'b0, ar.addr, '0, '0);
    handshake(1'b0, 1'b0, 1'b1);
    check_packets("mixed_ordering");
endtask

task automatic random_backpressure();
    logic [31:0] r;
    int          k;
    bp_mode = 2'd1;
    for (k = 0; k < 10; k++) begin
        r = $urandom;
        if (r[0]) begin
            ar.addr = {$urandom, $urandom};
            expect_packet(1'b0, ar.addr, '0, '0);
            handshake(1'b0, 1'b0, 1'b1);
        end else begin
            aw.addr = {$urandom, $urandom};
            w.data  = {$urandom, $urandom};
            w.strb  = r[15:8];
            expect_packet(1'b1, aw.addr, w.data, w.strb);
            handshake(1'b1, 1'b1, 1'b0);
        end
    end
    check_packets("random_backpressure");
    bp_mode = 2'd0;
endtask

task automatic queue_full_stall();
    int k;
    bp_mode = 2'd2;
    next_cycle();
    for (k = 0; k < 4; k++) begin
        aw.addr = 64'h8000 + 64'(k) * 64'd8;
        w.data  = {$urandom, $urandom};
        w.strb  = 8'h01 << k;
        expect_packet(1'b1, aw.addr, w.data, w.strb);
        handshake(1'b1, 1'b1, 1'b0);
    end
    if (aw_ready !== 1'b0) mismatch("aw_ready", 64'd0, 64'(aw_ready));
    aw.addr  = 64'h0000_0000_0000_9000;
    w.data   = {$urandom, $urandom};
    w.strb   = 8'hff;
    expect_packet(1'b1, aw.addr, w.data, w.strb);
    aw_valid = 1'b1;   // fifth address has to wait
    repeat (4) begin
        next_cycle();
        if (aw_ready !== 1'b0) mismatch("aw_ready", 64'd0, 64'(aw_ready));
    end
    bp_mode = 2'd0;
    handshake(1'b1, 1'b1, 1'b0);
    check_packets("queue_full_stall");
endtask

`endif

// File: tb/tb_axil_noc_bridge.sv
//##########################################################
// testbench for the AXI-Lite to NoC request bridge
// drives the AXI channels, records every flit handshake
// and runs the directed scenarios
//##########################################################
`timescale 1ns/10ps

module tb_axil_noc_bridge;

    localparam int TIMEOUT = 400;   // cycles allowed for any one wait

    logic                   clk = 1'b0;
    logic                   rst_n;
    bridge_pkg::node_id_t   src_id;
    bridge_pkg::node_id_t   dest_id;
    bridge_pkg::axil_aw_t   aw;
    logic                   aw_valid;
    logic                   aw_ready;
    bridge_pkg::axil_w_t    w;
    logic                   w_valid;
    logic                   w_ready;
    bridge_pkg::axil_aw_t   ar;
    logic                   ar_valid;
    logic                   ar_ready;
    logic                   noc_valid;
    bridge_pkg::flit_t      noc_data;
    logic                   noc_ready = 1'b1;
    logic [1:0]             bp_mode;        // 0 ready, 1 random, 2 stalled
    logic [31:0]            bp_rnd;
    bridge_pkg::flit_t      got_q[$];       // every flit taken by the network
    bridge_pkg::flit_t      exp_q[$];
    int                     errors;
    int                     timeouts;

    axil_noc_bridge u_dut (.*);

    always #4 clk = ~clk;

    // network side ready, changed just after the edge
    always @(posedge clk) begin
        #1;
        bp_rnd = $urandom;
        case (bp_mode)
            2'd1:    noc_ready = bp_rnd[0];
            2'd2:    noc_ready = 1'b0;
            default: noc_ready = 1'b1;
        endcase
    end

    // flit monitor
    always @(posedge clk) begin
        if (rst_n && noc_valid && noc_ready) got_q.push_back(noc_data);
    end

    `include "bridge_tb_tasks.svh"

    initial begin
        void'($urandom(32'h3a8eb40d));
        errors   = 0;
        timeouts = 0;
        bp_mode  = 2'd0;
        rst_n    = 1'b0;
        src_id   = '{14'h0012, 8'h03, 8'h05, 4'h0};
        dest_id  = '{14'h02a5, 8'h07, 8'h02, 4'h3};
        aw       = '0;
        aw_valid = 1'b0;
        w        = '0;
        w_valid  = 1'b0;
        ar       = '0;
        ar_valid = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        if (noc_valid !== 1'b0) mismatch("noc_valid", 64'd0, 64'(noc_valid));
        if (aw_ready !== 1'b1) mismatch("aw_ready", 64'd1, 64'(aw_ready));
        if (w_ready !== 1'b1) mismatch("w_ready", 64'd1, 64'(w_ready));
        if (ar_ready !== 1'b1) mismatch("ar_ready", 64'd1, 64'(ar_ready));

        single_load();
        single_store();
        write_data_first();
        mixed_ordering();
        random_backpressure();
        queue_full_stall();

        $display("checks finished with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
